//--- verif/bus_patterns.txt
# op addr size mask data expected_read name
# op is get, putf or putp; numbers in hex; size 0 byte, 1 halfword, 2 word
putf 00000100 2 f 11223344 00000000 wr_word_a
get  00000100 2 f 00000000 11223344 rd_word_a
putf 00000104 2 f 55667788 00000000 wr_word_a1
putp 00000105 0 1 000000aa 00000000 wr_byte_a1
putp 00000106 1 3 0000bbcc 00000000 wr_half_a1
putp 00000104 1 2 0000dd00 00000000 wr_half_partial
get  00000104 2 f 00000000 bbccdd88 rd_merged_word
get  00000106 0 1 00000000 000000cc rd_byte_lane2
get  00000107 0 1 00000000 000000bb rd_byte_lane3
get  00000104 1 3 00000000 0000dd88 rd_half_low
putp 00000108 2 5 a1b2c3d4 00000000 wr_word_mask5
get  00000108 2 f 00000000 00b200d4 rd_word_mask5
putf 00000200 2 f cafef00d 00000000 wr_block_b
get  00000200 2 f 00000000 cafef00d rd_block_b
get  00000100 2 f 00000000 11223344 rd_reload_a
get  00000104 2 f 00000000 bbccdd88 rd_reload_a1
get  00000108 2 f 00000000 00b200d4 rd_reload_a2
get  00000200 2 f 00000000 cafef00d rd_reload_b
putf 0000030c 2 f 0badbeef 00000000 wr_block_c
get  00000100 2 f 00000000 11223344 rd_evict_c
get  0000030c 2 f 00000000 0badbeef rd_reload_c
get  0000010c 2 f 00000000 00000000 rd_zero_word
putf 12345678 2 f 13579bdf 00000000 wr_high_addr
get  02345678 2 f 00000000 00000000 rd_other_block
get  32345678 2 f 00000000 13579bdf rd_alias_high

//--- list.f
source/ddr_bridge_pkg.sv
source/sync_fifo.sv
source/bus_port.sv
source/block_manager.sv
source/mig_adapter.sv
source/ddr_bridge_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_ddr_bridge.sv

//--- run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_ddr_bridge -o sim_ddr_bridge
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/sim_ddr_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- verif/tb_ddr_bridge.sv
`timescale 1ns/1ps

module tb_ddr_bridge;

  logic                     clk;
  logic                     rst_n;
  ddr_bridge_pkg::bus_req_t req_drv = '0;
  logic                     d_ready = 1'b0;
  ddr_bridge_pkg::bus_req_t bus_req;
  ddr_bridge_pkg::bus_rsp_t bus_rsp;
  ddr_bridge_pkg::app_cmd_t app_cmd;
  ddr_bridge_pkg::app_rsp_t app_rsp = '0;

  // patterns
  string       pat_op[$];
  string       pat_name[$];
  logic [31:0] pat_addr[$];
  logic [31:0] pat_size[$];
  logic [31:0] pat_mask[$];
  logic [31:0] pat_data[$];
  logic [31:0] pat_exp[$];
  int unsigned n_tests = 0;
  bit          loaded  = 1'b0;

  // memory model and reference
  logic [127:0] mem [int unsigned];
  logic [127:0] ref_mem [int unsigned];
  int unsigned  ref_idx     = 0;
  bit           ref_dirty   = 1'b0;
  int unsigned  exp_writes  = 0;
  int unsigned  write_count = 0;
  int unsigned  rd_key      = 0;
  int unsigned  rd_delay    = 0;
  int unsigned  wr_key      = 0;
  bit           wr_pending  = 1'b0;

  tb_clock_gen i_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  ddr_bridge_top i_ddr_bridge_top (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .bus_req_i(bus_req),
    .bus_rsp_o(bus_rsp),
    .app_cmd_o(app_cmd),
    .app_rsp_i(app_rsp)
  );

  tb_checker i_checker (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .bus_req_i(bus_req),
    .bus_rsp_i(bus_rsp)
  );

  always_comb begin
    bus_req         = req_drv;
    bus_req.d_ready = d_ready;
  end

  task automatic load_patterns();
    int          fd;
    int          cnt;
    string       line;
    string       op;
    string       name;
    logic [31:0] f [5];
    fd = $fopen("verif/bus_patterns.txt", "r");
    if (fd == 0) begin
      i_checker.note_error("cannot open verif/bus_patterns.txt");
      return;
    end
    while (!$feof(fd)) begin
      cnt = $fgets(line, fd);
      if (cnt == 0) break;
      if (line.len() < 2 || line[0] == 8'h23) continue;  // skip comments
      cnt = $sscanf(line, "%s %h %h %h %h %h %s", op, f[0], f[1], f[2], f[3], f[4], name);
      if (cnt != 7) continue;
      pat_op.push_back(op);
      pat_addr.push_back(f[0]);
      pat_size.push_back(f[1]);
      pat_mask.push_back(f[2]);
      pat_data.push_back(f[3]);
      pat_exp.push_back(f[4]);
      pat_name.push_back(name);
    end
    $fclose(fd);
    n_tests = pat_op.size();
  endtask

  // ------------------------------------------------------------------------
  // reference model of the one-block cache with writeback on dirty eviction
  task automatic update_ref(input bit is_write, input logic [31:0] addr, input int size,
                            input logic [31:0] mask, input logic [31:0] data);
    int unsigned  blk;
    int           nbytes;
    int           base;
    logic [127:0] blk_data;
    blk = 32'(addr[28:4]);
    if (blk != ref_idx) begin
      if (ref_dirty) exp_writes++;
      ref_idx   = blk;
      ref_dirty = 1'b0;
    end
    if (is_write) begin
      nbytes   = 1 << size;
      base     = 32'(addr[3:0]) & ~(nbytes - 1);
      blk_data = ref_mem.exists(blk) ? ref_mem[blk] : '0;
      for (int b = 0; b < nbytes; b++) begin
        if (mask[b]) blk_data[(base + b)*8 +: 8] = data[b*8 +: 8];
      end
      ref_mem[blk] = blk_data;
      ref_dirty    = 1'b1;
    end
  endtask

  task automatic run_test(input int t);
    bit is_get;
    is_get = (pat_op[t] == "get");
    @(negedge clk);
    while (!bus_rsp.a_ready) @(negedge clk);
    req_drv.a_valid   = 1'b1;
    req_drv.a_opcode  = is_get ? ddr_bridge_pkg::Get :
                        (pat_op[t] == "putf") ? ddr_bridge_pkg::PutFullData :
                                                ddr_bridge_pkg::PutPartialData;
    req_drv.a_address = pat_addr[t];
    req_drv.a_size    = pat_size[t][1:0];
    req_drv.a_mask    = pat_mask[t][3:0];
    req_drv.a_data    = pat_data[t];
    req_drv.a_source  = t[7:0];
    i_checker.expect_rsp(pat_name[t], is_get ? 32'd1 : 32'd0, pat_size[t], 32'(t[7:0]),
                         pat_exp[t], is_get);
    @(negedge clk);
    req_drv.a_valid = 1'b0;
    update_ref(!is_get, pat_addr[t], int'(pat_size[t]), pat_mask[t], pat_data[t]);
  endtask

  // ------------------------------------------------------------------------
  // bus back-pressure and memory model driven on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      d_ready = ($urandom % 4) != 0;
      app_rsp.app_rdy           = ($urandom % 3) != 0;
      app_rsp.app_wdf_rdy       = ($urandom % 3) != 0;
      app_rsp.app_rd_data_valid = 1'b0;
      if (rd_delay != 0) begin
        rd_delay--;
        if (rd_delay == 0) begin
          app_rsp.app_rd_data_valid = 1'b1;
          app_rsp.app_rd_data       = mem.exists(rd_key) ? mem[rd_key] : '0;
        end
      end
      // accepted on the coming rising edge
      if (app_cmd.app_en && app_rsp.app_rdy) begin
        if (app_cmd.app_cmd == ddr_bridge_pkg::APP_CMD_READ) begin
          rd_key   = 32'(app_cmd.app_addr[27:3]);
          rd_delay = 3 + ($urandom % 4);
        end else begin
          wr_key     = 32'(app_cmd.app_addr[27:3]);
          wr_pending = 1'b1;
        end
      end
      if (app_cmd.app_wdf_wren && app_rsp.app_wdf_rdy) begin
        if (!wr_pending) i_checker.note_error("write data arrived without a write command");
        mem[wr_key] = app_cmd.app_wdf_data;
        wr_pending  = 1'b0;
        write_count++;
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (n_tests * 200) @(posedge clk);
    $display("watchdog expired before all responses arrived");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(85871));
    load_patterns();
    loaded = 1'b1;
    wait (rst_n);
    for (int t = 0; t < int'(n_tests); t++) begin
      run_test(t);
    end
    wait (i_checker.rsp_count == n_tests);
    repeat (20) @(negedge clk);
    if (write_count != exp_writes) begin
      i_checker.note_error($sformatf("memory saw %0d writes but %0d dirty evictions happened",
                                     write_count, exp_writes));
    end
    foreach (ref_mem[k]) begin
      if (!(k == ref_idx && ref_dirty) && (mem.exists(k) ? mem[k] : '0) !== ref_mem[k]) begin
        i_checker.note_error($sformatf("memory block %h holds wrong data", k));
      end
    end
    $display("tests passed: %0d failed: %0d other errors: %0d", i_checker.pass_count,
             i_checker.fail_count, i_checker.error_count);
    if (i_checker.fail_count == 0 && i_checker.error_count == 0 && n_tests != 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input logic                     clk_i,
  input logic                     rst_ni,
  input ddr_bridge_pkg::bus_req_t bus_req_i,
  input ddr_bridge_pkg::bus_rsp_t bus_rsp_i
);

  string       name_q[$];
  logic [31:0] opcode_q[$];
  logic [31:0] size_q[$];
  logic [31:0] source_q[$];
  logic [31:0] data_q[$];
  logic        is_read_q[$];

  int unsigned              pass_count  = 0;
  int unsigned              fail_count  = 0;
  int unsigned              error_count = 0;
  int unsigned              rsp_count   = 0;
  logic                     stalled;
  ddr_bridge_pkg::bus_rsp_t held;

  task automatic expect_rsp(input string name, input logic [31:0] opcode, input logic [31:0] size,
                            input logic [31:0] source, input logic [31:0] data,
                            input logic is_read);
    name_q.push_back(name);
    opcode_q.push_back(opcode);
    size_q.push_back(size);
    source_q.push_back(source);
    data_q.push_back(data);
    is_read_q.push_back(is_read);
  endtask

  task automatic note_error(input string msg);
    $display("[ERROR] %s", msg);
    error_count++;
  endtask

  function automatic bit field_bad(input string name, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s %s expected %h actual %h", name, field, exp, act);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // ------------------------------------------------------------------------
  // compare each response as it is taken
  task automatic check_rsp();
    string name;
    bit    bad;
    if (name_q.size() == 0) begin
      note_error("response seen with no request outstanding");
      return;
    end
    name = name_q.pop_front();
    bad  = field_bad(name, "d_opcode", opcode_q.pop_front(), 32'(bus_rsp_i.d_opcode));
    bad |= field_bad(name, "d_size", size_q.pop_front(), 32'(bus_rsp_i.d_size));
    bad |= field_bad(name, "d_source", source_q.pop_front(), 32'(bus_rsp_i.d_source));
    if (is_read_q.pop_front()) begin  // write acks carry no data to check
      bad |= field_bad(name, "d_data", data_q.pop_front(), bus_rsp_i.d_data);
    end else begin
      void'(data_q.pop_front());
    end
    if (bad) begin
      fail_count++;
    end else begin
      $display("[PASS] %s", name);
      pass_count++;
    end
    rsp_count++;
  endtask

  always @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      stalled <= 1'b0;
      held    <= '0;
    end else begin
      // only one request may be outstanding
      if (bus_rsp_i.d_valid && bus_rsp_i.a_ready) begin
        note_error("a_ready was high while a response was waiting");
      end
      // a stalled response must hold until taken
      if (stalled && (!bus_rsp_i.d_valid || bus_rsp_i.d_opcode != held.d_opcode ||
          bus_rsp_i.d_size != held.d_size || bus_rsp_i.d_source != held.d_source ||
          bus_rsp_i.d_data != held.d_data)) begin
        note_error("response changed while d_ready was low");
      end
      if (bus_rsp_i.d_valid && bus_req_i.d_ready) begin
        check_rsp();
      end
      stalled <= bus_rsp_i.d_valid && !bus_req_i.d_ready;
      held    <= bus_rsp_i;
    end
  end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 100 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- source/ddr_bridge_top.sv
`timescale 1ns/1ps

module ddr_bridge_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ddr_bridge_pkg::bus_req_t bus_req_i,
  output ddr_bridge_pkg::bus_rsp_t bus_rsp_o,
  output ddr_bridge_pkg::app_cmd_t app_cmd_o,
  input  ddr_bridge_pkg::app_rsp_t app_rsp_i
);

  logic                     pending;
  logic                     write;
  ddr_bridge_pkg::blk_idx_t blk_idx;
  ddr_bridge_pkg::block_t   merge_data;
  ddr_bridge_pkg::block_t   merge_mask;
  logic                     hit;
  ddr_bridge_pkg::block_t   block;

  ddr_bridge_pkg::blk_req_t req;         // block manager side
  logic                     req_push;
  logic                     req_full;
  ddr_bridge_pkg::blk_req_t req_q;       // adapter side
  logic                     req_valid;
  logic                     req_pop;
  logic                     rd_valid;
  ddr_bridge_pkg::block_t   rd_data;

  bus_port i_bus_port (
    .clk_i,
    .rst_ni,
    .bus_req_i,
    .bus_rsp_o,
    .hit_i       (hit),
    .block_i     (block),
    .pending_o   (pending),
    .write_o     (write),
    .blk_idx_o   (blk_idx),
    .merge_data_o(merge_data),
    .merge_mask_o(merge_mask)
  );

  block_manager i_block_manager (
    .clk_i,
    .rst_ni,
    .pending_i   (pending),
    .write_i     (write),
    .blk_idx_i   (blk_idx),
    .merge_data_i(merge_data),
    .merge_mask_i(merge_mask),
    .hit_o       (hit),
    .block_o     (block),
    .req_o       (req),
    .req_push_o  (req_push),
    .req_full_i  (req_full),
    .rd_valid_i  (rd_valid),
    .rd_data_i   (rd_data)
  );

  sync_fifo #(
    .payload_t(ddr_bridge_pkg::blk_req_t)
  ) i_req_fifo (
    .clk_i,
    .rst_ni,
    .push_i (req_push),
    .data_i (req),
    .full_o (req_full),
    .valid_o(req_valid),
    .pop_i  (req_pop),
    .data_o (req_q)
  );

  // only one read is ever outstanding, so this one never fills
  sync_fifo #(
    .payload_t(ddr_bridge_pkg::block_t)
  ) i_rd_fifo (
    .clk_i,
    .rst_ni,
    .push_i (app_rsp_i.app_rd_data_valid),
    .data_i (app_rsp_i.app_rd_data),
    .full_o (),
    .valid_o(rd_valid),
    .pop_i  (1'b1),
    .data_o (rd_data)
  );

  mig_adapter i_mig_adapter (
    .clk_i,
    .rst_ni,
    .req_valid_i(req_valid),
    .req_i      (req_q),
    .req_pop_o  (req_pop),
    .app_cmd_o,
    .app_rsp_i
  );

endmodule

//--- source/mig_adapter.sv
`timescale 1ns/1ps

module mig_adapter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_valid_i,
  input  ddr_bridge_pkg::blk_req_t req_i,
  output logic                     req_pop_o,
  output ddr_bridge_pkg::app_cmd_t app_cmd_o,
  input  ddr_bridge_pkg::app_rsp_t app_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    CMD,
    WDATA
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  ddr_bridge_pkg::blk_req_t req_q;
  logic                     rdy_q;
  logic                     wdf_rdy_q;

  assign req_pop_o = (state_q == IDLE) && req_valid_i;

  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      req_q <= req_i;
    end
  end

  // --------------------------------------------------------------------------
  // ready flops sampled only while something is offered
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rdy_q     <= 1'b0;
      wdf_rdy_q <= 1'b0;
    end else begin
      rdy_q     <= app_rsp_i.app_rdy && app_cmd_o.app_en;
      wdf_rdy_q <= app_rsp_i.app_wdf_rdy && app_cmd_o.app_wdf_wren;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (req_valid_i) state_d = CMD;
      CMD: begin
        if (rdy_q) begin  // command taken
          state_d = req_q.write ? WDATA : IDLE;
        end
      end
      WDATA: if (wdf_rdy_q) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // block index in 16-bit words with the unused rank bit on top
  assign app_cmd_o.app_addr     = {1'b0, req_q.idx, 3'b000};
  assign app_cmd_o.app_cmd      = req_q.write ? ddr_bridge_pkg::APP_CMD_WRITE :
                                                ddr_bridge_pkg::APP_CMD_READ;
  assign app_cmd_o.app_en       = (state_q == CMD) && !rdy_q;
  assign app_cmd_o.app_wdf_data = req_q.data;
  assign app_cmd_o.app_wdf_wren = (state_q == WDATA) && !wdf_rdy_q;

endmodule

//--- source/block_manager.sv
`timescale 1ns/1ps

module block_manager (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     pending_i,
  input  logic                     write_i,
  input  ddr_bridge_pkg::blk_idx_t blk_idx_i,
  input  ddr_bridge_pkg::block_t   merge_data_i,
  input  ddr_bridge_pkg::block_t   merge_mask_i,
  output logic                     hit_o,
  output ddr_bridge_pkg::block_t   block_o,
  output ddr_bridge_pkg::blk_req_t req_o,
  output logic                     req_push_o,
  input  logic                     req_full_i,
  input  logic                     rd_valid_i,
  input  ddr_bridge_pkg::block_t   rd_data_i
);

  typedef enum logic [1:0] {
    IDLE,
    WRITEBACK,
    READ,
    WAIT
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  ddr_bridge_pkg::block_t   block_q;
  ddr_bridge_pkg::blk_idx_t idx_q;
  logic                     dirty_q;
  logic                     modify;
  logic                     load;

  assign hit_o   = (blk_idx_i == idx_q);
  assign block_o = block_q;
  assign modify  = pending_i && hit_o && write_i;
  assign load    = (state_q == WAIT) && rd_valid_i;

  // --------------------------------------------------------------------------
  // cached block starts as clean block 0
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      block_q <= '0;
      idx_q   <= '0;
      dirty_q <= 1'b0;
    end else if (load) begin
      block_q <= rd_data_i;
      idx_q   <= blk_idx_i;
      dirty_q <= 1'b0;
    end else if (modify) begin
      block_q <= (block_q & ~merge_mask_i) | (merge_data_i & merge_mask_i);
      dirty_q <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // miss handling
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (pending_i && !hit_o) begin
          state_d = dirty_q ? WRITEBACK : READ;
        end
      end
      WRITEBACK: begin
        if (!req_full_i) begin
          state_d = READ;
        end
      end
      READ: begin
        if (!req_full_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (rd_valid_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // writeback sends the old block, read asks for the new index
  assign req_push_o = (state_q == WRITEBACK) || (state_q == READ);
  assign req_o.write = (state_q == WRITEBACK);
  assign req_o.idx   = req_o.write ? idx_q : blk_idx_i;
  assign req_o.data  = block_q;

endmodule

//--- source/bus_port.sv
`timescale 1ns/1ps

module bus_port (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ddr_bridge_pkg::bus_req_t bus_req_i,
  output ddr_bridge_pkg::bus_rsp_t bus_rsp_o,
  input  logic                     hit_i,
  input  ddr_bridge_pkg::block_t   block_i,
  output logic                     pending_o,
  output logic                     write_o,
  output ddr_bridge_pkg::blk_idx_t blk_idx_o,
  output ddr_bridge_pkg::block_t   merge_data_o,
  output ddr_bridge_pkg::block_t   merge_mask_o
);

  logic                                  pending_q;
  ddr_bridge_pkg::opcode_e               opcode_q;
  logic [ddr_bridge_pkg::BUS_SZW-1:0]    size_q;
  logic [ddr_bridge_pkg::BUS_IDW-1:0]    source_q;
  logic [ddr_bridge_pkg::BUS_AW-1:0]     addr_q;
  logic [ddr_bridge_pkg::BUS_MW-1:0]     mask_q;
  logic [ddr_bridge_pkg::BUS_DW-1:0]     data_q;

  logic                                  a_fire;
  logic                                  d_fire;
  logic [ddr_bridge_pkg::BUS_DW-1:0]     mask_bits;
  ddr_bridge_pkg::bus_rsp_t              rsp;

  assign a_fire    = bus_req_i.a_valid && !pending_q;
  assign d_fire    = pending_q && hit_i && bus_req_i.d_ready;
  assign pending_o = pending_q;
  assign write_o   = (opcode_q != ddr_bridge_pkg::Get);
  assign blk_idx_o = addr_q[28:4];
  assign bus_rsp_o = rsp;

  // --------------------------------------------------------------------------
  // request capture with one outstanding at a time
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (a_fire) begin
      pending_q <= 1'b1;
    end else if (d_fire) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      opcode_q <= bus_req_i.a_opcode;
      size_q   <= bus_req_i.a_size;
      source_q <= bus_req_i.a_source;
      addr_q   <= bus_req_i.a_address;
      mask_q   <= bus_req_i.a_mask;
      data_q   <= bus_req_i.a_data;
    end
  end

  // --------------------------------------------------------------------------
  // response and lane handling
  always_comb begin
    for (int i = 0; i < ddr_bridge_pkg::BUS_MW; i++) begin
      mask_bits[i*8 +: 8] = {8{mask_q[i]}};
    end

    rsp          = '0;
    rsp.a_ready  = !pending_q;
    rsp.d_valid  = pending_q && hit_i;  // response once the block is loaded
    rsp.d_opcode = (opcode_q == ddr_bridge_pkg::Get) ? ddr_bridge_pkg::AccessAckData :
                                                       ddr_bridge_pkg::AccessAck;
    rsp.d_size   = size_q;
    rsp.d_source = source_q;
    merge_data_o = '0;
    merge_mask_o = '0;

    case (size_q)
      2'd0: begin  // byte
        rsp.d_data[7:0]                   = block_i[addr_q[3:0]*8 +: 8];
        merge_mask_o[addr_q[3:0]*8 +: 8]  = mask_bits[7:0];
        merge_data_o[addr_q[3:0]*8 +: 8]  = data_q[7:0];
      end
      2'd1: begin  // halfword
        rsp.d_data[15:0]                  = block_i[addr_q[3:1]*16 +: 16];
        merge_mask_o[addr_q[3:1]*16 +: 16] = mask_bits[15:0];
        merge_data_o[addr_q[3:1]*16 +: 16] = data_q[15:0];
      end
      2'd2: begin  // word
        rsp.d_data                        = block_i[addr_q[3:2]*32 +: 32];
        merge_mask_o[addr_q[3:2]*32 +: 32] = mask_bits;
        merge_data_o[addr_q[3:2]*32 +: 32] = data_q;
      end
      default: begin
        rsp.d_data = '0;  // wider sizes not supported
      end
    endcase

    // write acks carry no data while the merge repeats
    if (write_o) begin
      rsp.d_data = '0;
    end
  end

endmodule

//--- source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  output logic     valid_o,
  input  logic     pop_i,
  output payload_t data_o
);

  payload_t                                 mem_q [ddr_bridge_pkg::FIFO_DEPTH];
  logic [ddr_bridge_pkg::FIFO_PTR_W-1:0]    wr_ptr_q;
  logic [ddr_bridge_pkg::FIFO_PTR_W-1:0]    rd_ptr_q;
  logic [ddr_bridge_pkg::FIFO_CNT_W-1:0]    count_q;
  logic                                     push_ok;
  logic                                     pop_ok;

  assign full_o  = (count_q == ddr_bridge_pkg::FIFO_CNT_W'(ddr_bridge_pkg::FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push_ok = push_i && !full_o;  // push into a full FIFO is dropped
  assign pop_ok  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == ddr_bridge_pkg::FIFO_PTR_W'(ddr_bridge_pkg::FIFO_DEPTH - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == ddr_bridge_pkg::FIFO_PTR_W'(ddr_bridge_pkg::FIFO_DEPTH - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle or push and pop together
      endcase
    end
  end

endmodule

//--- source/ddr_bridge_pkg.sv
package ddr_bridge_pkg;

  // bus widths
  localparam int unsigned BUS_AW  = 32;
  localparam int unsigned BUS_DW  = 32;
  localparam int unsigned BUS_MW  = 4;
  localparam int unsigned BUS_SZW = 2;
  localparam int unsigned BUS_IDW = 8;

  // block and controller widths
  localparam int unsigned BLOCK_W   = 128;
  localparam int unsigned BLOCK_AW  = 25;   // bus address bits 28:4
  localparam int unsigned APP_AW    = 29;   // 16-bit word address
  localparam int unsigned APP_CMD_W = 3;

  localparam logic [APP_CMD_W-1:0] APP_CMD_WRITE = 3'd0;
  localparam logic [APP_CMD_W-1:0] APP_CMD_READ  = 3'd1;

  // both FIFOs
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [BLOCK_W-1:0]  block_t;
  typedef logic [BLOCK_AW-1:0] blk_idx_t;

  // TileLink channel A and D opcodes
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } opcode_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } rsp_opcode_e;

  typedef struct packed {
    logic                a_valid;
    opcode_e             a_opcode;
    logic [BUS_SZW-1:0]  a_size;
    logic [BUS_AW-1:0]   a_address;
    logic [BUS_MW-1:0]   a_mask;
    logic [BUS_DW-1:0]   a_data;
    logic [BUS_IDW-1:0]  a_source;
    logic                d_ready;
  } bus_req_t;

  typedef struct packed {
    logic                a_ready;
    logic                d_valid;
    rsp_opcode_e         d_opcode;
    logic [BUS_SZW-1:0]  d_size;
    logic [BUS_IDW-1:0]  d_source;
    logic [BUS_DW-1:0]   d_data;
  } bus_rsp_t;

  typedef struct packed {
    logic     write;
    blk_idx_t idx;
    block_t   data;
  } blk_req_t;

  typedef struct packed {
    logic [APP_AW-1:0]    app_addr;
    logic [APP_CMD_W-1:0] app_cmd;
    logic                 app_en;
    block_t               app_wdf_data;
    logic                 app_wdf_wren;
  } app_cmd_t;

  typedef struct packed {
    logic   app_rdy;
    logic   app_wdf_rdy;
    block_t app_rd_data;
    logic   app_rd_data_valid;
  } app_rsp_t;

endpackage
